/* design/mips_pkg.sv */
// mips pipeline shared definitions
package mips_pkg;

   localparam int WORD_W    = 32;
   localparam int REG_IDX_W = 5;
   localparam int NUM_REGS  = 2 ** REG_IDX_W;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_J     = 6'h02,
      OP_BEQ   = 6'h04,
      OP_ADDI  = 6'h08,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b
   } opcode_t;

   typedef enum logic [5:0] {
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2a
   } funct_t;

   // class of operation chosen by decode
   typedef enum logic [1:0] {
      ALUOP_ADD   = 2'b00,
      ALUOP_SUB   = 2'b01,
      ALUOP_FUNCT = 2'b10
   } alu_op_t;

   typedef enum logic [3:0] {
      AND = 4'b0000,
      OR  = 4'b0001,
      ADD = 4'b0010,
      SUB = 4'b0110,
      SLT = 4'b0111
   } alu_ctrl_t;

   // one instruction word, three encodings
   typedef union packed {
      struct packed {
         opcode_t    opcode;
         reg_idx_t   rs;
         reg_idx_t   rt;
         reg_idx_t   rd;
         logic [4:0] shamt;
         funct_t     funct;
      } r_fmt;
      struct packed {
         opcode_t     opcode;
         reg_idx_t    rs;
         reg_idx_t    rt;
         logic [15:0] imm;
      } i_fmt;
      struct packed {
         opcode_t     opcode;
         logic [25:0] target;
      } j_fmt;
   } instr_u;

   typedef enum logic [1:0] {
      FWD_REG   = 2'b00,
      FWD_MEMWB = 2'b01,
      FWD_EXMEM = 2'b10
   } fwd_sel_t;

   localparam word_t NOP_WORD = '0;

endpackage

/* design/pc_unit.sv */
// program counter
module pc_unit (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            stall_i,
   input  logic            branch_taken_i,
   input  mips_pkg::word_t branch_target_i,
   input  logic            jump_taken_i,
   input  mips_pkg::word_t jump_target_i,
   output mips_pkg::word_t pc_o,
   output mips_pkg::word_t pc_plus4_o
);
   import mips_pkg::*;

   word_t pc_next;

   assign pc_plus4_o = pc_o + word_t'(4);

   // branch from execute beats jump from decode
   always_comb begin
      if (branch_taken_i) begin
         pc_next = branch_target_i;
      end else if (jump_taken_i) begin
         pc_next = jump_target_i;
      end else begin
         pc_next = pc_plus4_o;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_o <= '0;
      end else if (!stall_i) begin
         pc_o <= pc_next;
      end
   end

endmodule

/* design/main_ctrl.sv */
// main instruction decoder
module main_ctrl (
   input  mips_pkg::instr_u  instr_i,
   input  logic              bubble_i,
   output logic              reg_dst_o,
   output logic              alu_src_o,
   output logic              mem_read_o,
   output logic              mem_write_o,
   output logic              mem_to_reg_o,
   output logic              reg_write_o,
   output logic              branch_o,
   output logic              jump_o,
   output mips_pkg::alu_op_t alu_op_o
);
   import mips_pkg::*;

   always_comb begin
      reg_dst_o    = 1'b0;
      alu_src_o    = 1'b0;
      mem_read_o   = 1'b0;
      mem_write_o  = 1'b0;
      mem_to_reg_o = 1'b0;
      reg_write_o  = 1'b0;
      branch_o     = 1'b0;
      jump_o       = 1'b0;
      alu_op_o     = ALUOP_ADD;
      // bubble or unknown opcode leaves all off
      if (!bubble_i) begin
         case (instr_i.r_fmt.opcode)
            OP_RTYPE: begin
               reg_dst_o   = 1'b1;
               reg_write_o = 1'b1;
               alu_op_o    = ALUOP_FUNCT;
            end
            OP_ADDI: begin
               alu_src_o   = 1'b1;
               reg_write_o = 1'b1;
            end
            OP_LW: begin
               alu_src_o    = 1'b1;
               mem_read_o   = 1'b1;
               mem_to_reg_o = 1'b1;
               reg_write_o  = 1'b1;
            end
            OP_SW: begin
               alu_src_o   = 1'b1;
               mem_write_o = 1'b1;
            end
            OP_BEQ: begin
               branch_o = 1'b1;
               alu_op_o = ALUOP_SUB;
            end
            OP_J: begin
               jump_o = 1'b1;
            end
            default: begin
               jump_o = 1'b0;
            end
         endcase
      end
   end

endmodule

/* design/alu.sv */
// alu with operation decode
module alu (
   input  mips_pkg::alu_op_t alu_op_i,
   input  mips_pkg::funct_t  funct_i,
   input  mips_pkg::word_t   op_a_i,
   input  mips_pkg::word_t   op_b_i,
   output mips_pkg::word_t   result_o,
   output logic              zero_o
);
   import mips_pkg::*;

   alu_ctrl_t ctrl;

   always_comb begin
      case (alu_op_i)
         ALUOP_SUB: begin
            ctrl = SUB;
         end
         ALUOP_FUNCT: begin
            case (funct_i)
               FN_SUB:  ctrl = SUB;
               FN_AND:  ctrl = AND;
               FN_OR:   ctrl = OR;
               FN_SLT:  ctrl = SLT;
               default: ctrl = ADD;
            endcase
         end
         default: begin
            ctrl = ADD;
         end
      endcase
   end

   // overflow is not trapped
   always_comb begin
      case (ctrl)
         AND:     result_o = op_a_i & op_b_i;
         OR:      result_o = op_a_i | op_b_i;
         SUB:     result_o = op_a_i - op_b_i;
         SLT:     result_o = word_t'($signed(op_a_i) < $signed(op_b_i));
         default: result_o = op_a_i + op_b_i;
      endcase
   end

   // beq compares through sub
   assign zero_o = (result_o == '0);

endmodule

/* design/regfile.sv */
// register file with write-through reads
module regfile #(
   parameter int LED_REG = 3
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mips_pkg::reg_idx_t rd_addr_a_i,
   input  mips_pkg::reg_idx_t rd_addr_b_i,
   input  mips_pkg::reg_idx_t wr_addr_i,
   input  mips_pkg::word_t    wr_data_i,
   input  logic               wr_en_i,
   output mips_pkg::word_t    rd_data_a_o,
   output mips_pkg::word_t    rd_data_b_o,
   output logic [7:0]         led_o
);
   import mips_pkg::*;

   word_t regs [NUM_REGS];
   logic  wr_live;

   // r0 is never written
   assign wr_live = wr_en_i && (wr_addr_i != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // same-cycle writeback shows up in decode
   always_comb begin
      rd_data_a_o = (wr_live && rd_addr_a_i == wr_addr_i) ? wr_data_i : regs[rd_addr_a_i];
      rd_data_b_o = (wr_live && rd_addr_b_i == wr_addr_i) ? wr_data_i : regs[rd_addr_b_i];
   end

   assign led_o = regs[LED_REG][7:0];

endmodule

/* design/hazard_unit.sv */
// forwarding and load-use detection
module hazard_unit (
   input  mips_pkg::reg_idx_t idex_rs_i,
   input  mips_pkg::reg_idx_t idex_rt_i,
   input  mips_pkg::reg_idx_t idex_rt_load_i,
   input  mips_pkg::reg_idx_t ifid_rs_i,
   input  mips_pkg::reg_idx_t ifid_rt_i,
   input  mips_pkg::reg_idx_t exmem_rd_i,
   input  mips_pkg::reg_idx_t memwb_rd_i,
   input  logic               idex_mem_read_i,
   input  logic               exmem_reg_write_i,
   input  logic               memwb_reg_write_i,
   input  mips_pkg::word_t    reg_a_i,
   input  mips_pkg::word_t    reg_b_i,
   input  mips_pkg::word_t    exmem_result_i,
   input  mips_pkg::word_t    memwb_result_i,
   output mips_pkg::word_t    op_a_o,
   output mips_pkg::word_t    op_b_o,
   output logic               load_use_stall_o
);
   import mips_pkg::*;

   fwd_sel_t sel_a;
   fwd_sel_t sel_b;

   // newest producer wins
   function automatic fwd_sel_t pick_src(input reg_idx_t src);
      if (src == '0) return FWD_REG;
      if (exmem_reg_write_i && exmem_rd_i == src) return FWD_EXMEM;
      if (memwb_reg_write_i && memwb_rd_i == src) return FWD_MEMWB;
      return FWD_REG;
   endfunction

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
      case (sel)
         FWD_EXMEM: return exmem_result_i;
         FWD_MEMWB: return memwb_result_i;
         default:   return reg_val;
      endcase
   endfunction

   always_comb begin
      sel_a  = pick_src(idex_rs_i);
      sel_b  = pick_src(idex_rt_i);
      op_a_o = fwd_mux(sel_a, reg_a_i);
      op_b_o = fwd_mux(sel_b, reg_b_i);
   end

   // load result not ready until after mem
   assign load_use_stall_o = idex_mem_read_i && (idex_rt_load_i != '0) &&
                             (idex_rt_load_i == ifid_rs_i || idex_rt_load_i == ifid_rt_i);

endmodule

/* design/data_ram.sv */
// data memory
module data_ram #(
   parameter int DMEM_WORDS = 64
) (
   input  logic            clk,
   input  mips_pkg::word_t addr_i,
   input  mips_pkg::word_t wr_data_i,
   input  logic            wr_en_i,
   output mips_pkg::word_t rd_data_o
);
   import mips_pkg::*;

   localparam int IDX_W = $clog2(DMEM_WORDS);

   word_t            mem [DMEM_WORDS];
   logic [IDX_W-1:0] idx;

   // byte address to word index, wraps at depth
   assign idx = IDX_W'((addr_i >> 2) % DMEM_WORDS);

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[idx] <= wr_data_i;
      end
   end

   assign rd_data_o = mem[idx];

endmodule

/* design/mips_pipe_top.sv */
// five-stage mips pipeline core
module mips_pipe_top #(
   parameter int DMEM_WORDS = 64,
   parameter int LED_REG    = 3
) (
   input  logic            clk,
   input  logic            rst_n,
   output mips_pkg::word_t imem_addr_o,
   input  mips_pkg::word_t imem_data_i,
   output logic [7:0]      led_o
);
   import mips_pkg::*;

   word_t     pc;
   word_t     pc_plus4;
   logic      stall;
   logic      load_use_stall;
   logic      branch_taken;
   word_t     branch_target;
   word_t     jump_target;
   logic      ifid_flush;
   instr_u    ifid_instr;
   word_t     ifid_pc_plus4;

   logic      id_reg_dst;
   logic      id_alu_src;
   logic      id_mem_read;
   logic      id_mem_write;
   logic      id_mem_to_reg;
   logic      id_reg_write;
   logic      id_branch;
   logic      id_jump;
   alu_op_t   id_alu_op;
   word_t     id_rd_a;
   word_t     id_rd_b;
   word_t     id_imm_ext;

   logic      idex_reg_dst;
   logic      idex_alu_src;
   logic      idex_mem_read;
   logic      idex_mem_write;
   logic      idex_mem_to_reg;
   logic      idex_reg_write;
   logic      idex_branch;
   alu_op_t   idex_alu_op;
   reg_idx_t  idex_rs;
   reg_idx_t  idex_rt;
   reg_idx_t  idex_rd;
   funct_t    idex_funct;
   word_t     idex_imm_ext;
   word_t     idex_pc_plus4;
   word_t     idex_reg_a;
   word_t     idex_reg_b;

   word_t     ex_op_a;
   word_t     ex_op_b;
   word_t     ex_alu_b;
   word_t     ex_result;
   logic      ex_zero;
   reg_idx_t  ex_wr_reg;

   logic      exmem_mem_write;
   logic      exmem_mem_to_reg;
   logic      exmem_reg_write;
   word_t     exmem_result;
   word_t     exmem_store;
   reg_idx_t  exmem_wr_reg;
   word_t     mem_rd_data;

   logic      memwb_mem_to_reg;
   logic      memwb_reg_write;
   word_t     memwb_result;
   word_t     memwb_load;
   reg_idx_t  memwb_wr_reg;
   word_t     wb_data;

   assign branch_taken  = idex_branch & ex_zero;
   assign stall         = load_use_stall;
   assign ifid_flush    = branch_taken | id_jump;
   assign jump_target   = {ifid_pc_plus4[31:28], ifid_instr.j_fmt.target, 2'b00};
   assign branch_target = idex_pc_plus4 + {idex_imm_ext[29:0], 2'b00};
   assign imem_addr_o   = pc;

   pc_unit u_pc (
      .clk             (clk),
      .rst_n           (rst_n),
      .stall_i         (stall),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .jump_taken_i    (id_jump),
      .jump_target_i   (jump_target),
      .pc_o            (pc),
      .pc_plus4_o      (pc_plus4)
   );

   always_ff @(posedge clk) begin
      if (!rst_n || ifid_flush) begin
         ifid_instr <= NOP_WORD;
      end else if (!stall) begin
         ifid_instr    <= imem_data_i;
         ifid_pc_plus4 <= pc_plus4;
      end
   end

   // decode
   main_ctrl u_ctrl (
      .instr_i      (ifid_instr),
      .bubble_i     (load_use_stall | branch_taken),
      .reg_dst_o    (id_reg_dst),
      .alu_src_o    (id_alu_src),
      .mem_read_o   (id_mem_read),
      .mem_write_o  (id_mem_write),
      .mem_to_reg_o (id_mem_to_reg),
      .reg_write_o  (id_reg_write),
      .branch_o     (id_branch),
      .jump_o       (id_jump),
      .alu_op_o     (id_alu_op)
   );

   regfile #(
      .LED_REG (LED_REG)
   ) u_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_addr_a_i (ifid_instr.r_fmt.rs),
      .rd_addr_b_i (ifid_instr.r_fmt.rt),
      .wr_addr_i   (memwb_wr_reg),
      .wr_data_i   (wb_data),
      .wr_en_i     (memwb_reg_write),
      .rd_data_a_o (id_rd_a),
      .rd_data_b_o (id_rd_b),
      .led_o       (led_o)
   );

   assign id_imm_ext = {{16{ifid_instr.i_fmt.imm[15]}}, ifid_instr.i_fmt.imm};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idex_reg_dst    <= 1'b0;
         idex_alu_src    <= 1'b0;
         idex_mem_read   <= 1'b0;
         idex_mem_write  <= 1'b0;
         idex_mem_to_reg <= 1'b0;
         idex_reg_write  <= 1'b0;
         idex_branch     <= 1'b0;
         idex_alu_op     <= ALUOP_ADD;
      end else begin
         // controls arrive already zeroed for a bubble
         idex_reg_dst    <= id_reg_dst;
         idex_alu_src    <= id_alu_src;
         idex_mem_read   <= id_mem_read;
         idex_mem_write  <= id_mem_write;
         idex_mem_to_reg <= id_mem_to_reg;
         idex_reg_write  <= id_reg_write;
         idex_branch     <= id_branch;
         idex_alu_op     <= id_alu_op;
         idex_rs         <= ifid_instr.r_fmt.rs;
         idex_rt         <= ifid_instr.r_fmt.rt;
         idex_rd         <= ifid_instr.r_fmt.rd;
         idex_funct      <= ifid_instr.r_fmt.funct;
         idex_imm_ext    <= id_imm_ext;
         idex_pc_plus4   <= ifid_pc_plus4;
         idex_reg_a      <= id_rd_a;
         idex_reg_b      <= id_rd_b;
      end
   end

   // execute
   assign ex_wr_reg = idex_reg_dst ? idex_rd : idex_rt;
   assign ex_alu_b  = idex_alu_src ? idex_imm_ext : ex_op_b;

   hazard_unit u_hazard (
      .idex_rs_i         (idex_rs),
      .idex_rt_i         (idex_rt),
      .idex_rt_load_i    (ex_wr_reg),
      .ifid_rs_i         (ifid_instr.r_fmt.rs),
      .ifid_rt_i         (ifid_instr.r_fmt.rt),
      .exmem_rd_i        (exmem_wr_reg),
      .memwb_rd_i        (memwb_wr_reg),
      .idex_mem_read_i   (idex_mem_read),
      .exmem_reg_write_i (exmem_reg_write),
      .memwb_reg_write_i (memwb_reg_write),
      .reg_a_i           (idex_reg_a),
      .reg_b_i           (idex_reg_b),
      .exmem_result_i    (exmem_result),
      .memwb_result_i    (wb_data),
      .op_a_o            (ex_op_a),
      .op_b_o            (ex_op_b),
      .load_use_stall_o  (load_use_stall)
   );

   alu u_alu (
      .alu_op_i (idex_alu_op),
      .funct_i  (idex_funct),
      .op_a_i   (ex_op_a),
      .op_b_i   (ex_alu_b),
      .result_o (ex_result),
      .zero_o   (ex_zero)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exmem_mem_write  <= 1'b0;
         exmem_mem_to_reg <= 1'b0;
         exmem_reg_write  <= 1'b0;
      end else begin
         exmem_mem_write  <= idex_mem_write;
         exmem_mem_to_reg <= idex_mem_to_reg;
         exmem_reg_write  <= idex_reg_write;
         exmem_result     <= ex_result;
         exmem_store      <= ex_op_b;
         exmem_wr_reg     <= ex_wr_reg;
      end
   end

   // memory
   data_ram #(
      .DMEM_WORDS (DMEM_WORDS)
   ) u_dmem (
      .clk       (clk),
      .addr_i    (exmem_result),
      .wr_data_i (exmem_store),
      .wr_en_i   (exmem_mem_write),
      .rd_data_o (mem_rd_data)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         memwb_mem_to_reg <= 1'b0;
         memwb_reg_write  <= 1'b0;
      end else begin
         memwb_mem_to_reg <= exmem_mem_to_reg;
         memwb_reg_write  <= exmem_reg_write;
         memwb_result     <= exmem_result;
         memwb_load       <= mem_rd_data;
         memwb_wr_reg     <= exmem_wr_reg;
      end
   end

   // writeback
   assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_result;

endmodule

/* bench/mips_pipe_asserts.sv */
// pipeline control assertions
module mips_pipe_asserts (
   input logic            clk,
   input logic            rst_n,
   input mips_pkg::word_t imem_addr_o,
   input mips_pkg::word_t pc,
   input logic            load_use_stall,
   input logic            idex_mem_write,
   input logic            idex_reg_write,
   input logic            exmem_mem_write,
   input logic            exmem_reg_write,
   input logic            memwb_reg_write
);

   addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      imem_addr_o[1:0] == 2'b00)
      else $error("imem_addr_o is not word aligned");

   // bubble cycle holds fetch
   stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      load_use_stall |=> $stable(pc))
      else $error("pc moved during a load-use stall");

   // first reset edge clears them, checked from the second on
   writes_off_in_reset: assert property (@(posedge clk)
      (!rst_n && $past(!rst_n)) |-> !(idex_mem_write || idex_reg_write ||
                                      exmem_mem_write || exmem_reg_write || memwb_reg_write))
      else $error("write control active during reset");

endmodule

bind mips_pipe_top mips_pipe_asserts u_asserts (
   .clk             (clk),
   .rst_n           (rst_n),
   .imem_addr_o     (imem_addr_o),
   .pc              (pc),
   .load_use_stall  (load_use_stall),
   .idex_mem_write  (idex_mem_write),
   .idex_reg_write  (idex_reg_write),
   .exmem_mem_write (exmem_mem_write),
   .exmem_reg_write (exmem_reg_write),
   .memwb_reg_write (memwb_reg_write)
);

/* bench/mips_pipe_tb.sv */
// mips pipeline testbench
module mips_pipe_tb;
   import mips_pkg::*;

   localparam int NUM_ROWS     = 8;
   localparam int PROG_WORDS   = 12;
   localparam int ROM_WORDS    = 16;
   localparam int RESET_CYCLES = 8;
   localparam int RUN_CYCLES   = 40;
   localparam int LED_REG      = 3;
   // rows times reset plus run, small slack for the first edge
   localparam int MAX_CYCLES   = NUM_ROWS * (RESET_CYCLES + RUN_CYCLES) + 4;

   logic       clk;
   logic       rst_n;
   word_t      imem_addr;
   word_t      imem_data;
   logic [7:0] led;

   word_t      rom [ROM_WORDS];
   word_t      prog_tab [NUM_ROWS][PROG_WORDS];
   logic [7:0] exp_tab [NUM_ROWS];
   int         end_idx [NUM_ROWS];
   word_t      lcg_state;
   int         cycles = 0;
   int         errors;

   mips_pipe_top #(
      .DMEM_WORDS (64),
      .LED_REG    (LED_REG)
   ) DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_addr_o (imem_addr),
      .imem_data_i (imem_data),
      .led_o       (led)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   function automatic word_t fetch_word(input word_t addr);
      if ((addr >> 2) < word_t'(ROM_WORDS)) begin
         return rom[addr[5:2]];
      end
      return NOP_WORD;
   endfunction

   // rom answers the current pc before the next rising edge
   always @(negedge clk) begin
      imem_data = fetch_word(imem_addr);
   end

   function automatic logic [15:0] rand_imm();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   function automatic word_t sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic word_t asm_r(input funct_t fn, input int rd, input int rs, input int rt);
      return {OP_RTYPE, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), 5'd0, fn};
   endfunction

   // addi rt, rs, imm / lw rt, imm(rs) / sw rt, imm(rs) / beq rs, rt, imm
   function automatic word_t asm_i(input opcode_t op, input int rt, input int rs,
                                   input logic [15:0] imm);
      return {op, reg_idx_t'(rs), reg_idx_t'(rt), imm};
   endfunction

   function automatic word_t asm_j(input int idx);
      return {OP_J, 26'(idx)};
   endfunction

   task automatic stop_on_error();
      errors++;
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_addr_bound(input int last);
      word_t limit;
      limit = word_t'(last * 4 + 4);
      if (imem_addr > limit) begin
         $display("FAIL t=%0t imem_addr_o got %h above limit %h", $time, imem_addr, limit);
         stop_on_error();
      end
   endtask

   // final self-jump closes every program
   task automatic close_row(input int row, input int idx, input word_t result);
      prog_tab[row][idx] = asm_j(idx);
      end_idx[row]       = idx;
      exp_tab[row]       = result[7:0];
   endtask

   task automatic build_table();
      logic [15:0] r1;
      logic [15:0] r2;
      logic [15:0] r3;
      word_t       a;
      word_t       b;
      word_t       v;
      foreach (prog_tab[i, j]) begin
         prog_tab[i][j] = NOP_WORD;
      end
      // add/sub chain through both forwarding paths
      r1 = rand_imm();
      r2 = rand_imm();
      prog_tab[0][0] = asm_i(OP_ADDI, 1, 0, r1);
      prog_tab[0][1] = asm_i(OP_ADDI, 2, 1, r2);
      prog_tab[0][2] = asm_r(FN_ADD, LED_REG, 1, 2);
      prog_tab[0][3] = asm_r(FN_SUB, LED_REG, LED_REG, 1);
      a = sext16(r1);
      b = a + sext16(r2);
      close_row(0, 4, (a + b) - a);
      // and, or, slt mix
      r1 = rand_imm();
      r2 = rand_imm();
      prog_tab[1][0] = asm_i(OP_ADDI, 1, 0, r1);
      prog_tab[1][1] = asm_i(OP_ADDI, 2, 0, r2);
      prog_tab[1][2] = asm_r(FN_AND, 4, 1, 2);
      prog_tab[1][3] = asm_r(FN_OR, 5, 1, 2);
      prog_tab[1][4] = asm_r(FN_SUB, LED_REG, 5, 4);
      prog_tab[1][5] = asm_r(FN_SLT, 6, 1, 2);
      prog_tab[1][6] = asm_r(FN_ADD, LED_REG, LED_REG, 6);
      a = sext16(r1);
      b = sext16(r2);
      v = (a | b) - (a & b);
      v = v + (($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      close_row(1, 7, v);
      // slt must compare signed, -5 against 3
      prog_tab[2][0] = asm_i(OP_ADDI, 1, 0, 16'hfffb);
      prog_tab[2][1] = asm_i(OP_ADDI, 2, 0, 16'h0003);
      prog_tab[2][2] = asm_r(FN_SLT, LED_REG, 1, 2);
      prog_tab[2][3] = asm_r(FN_SLT, 4, 2, 1);
      prog_tab[2][4] = asm_r(FN_SUB, LED_REG, LED_REG, 4);
      prog_tab[2][5] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0040);
      close_row(2, 6, 32'd1 - 32'd0 + 32'h40);
      // store, load, then use the load at once
      r3 = rand_imm();
      prog_tab[3][0] = asm_i(OP_ADDI, 1, 0, r3);
      prog_tab[3][1] = asm_i(OP_ADDI, 2, 0, 16'h0008);
      prog_tab[3][2] = asm_i(OP_SW, 1, 2, 16'h0004);
      prog_tab[3][3] = asm_i(OP_LW, 4, 2, 16'h0004);
      prog_tab[3][4] = asm_i(OP_ADDI, LED_REG, 4, 16'h0001);
      close_row(3, 5, sext16(r3) + 32'd1);
      // beq taken skips two writes to the led register
      prog_tab[4][0] = asm_i(OP_ADDI, 1, 0, 16'h0007);
      prog_tab[4][1] = asm_i(OP_ADDI, 2, 0, 16'h0007);
      prog_tab[4][2] = asm_i(OP_BEQ, 2, 1, 16'h0002);
      prog_tab[4][3] = asm_i(OP_ADDI, LED_REG, 0, 16'h0011);
      prog_tab[4][4] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0022);
      prog_tab[4][5] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0030);
      close_row(4, 6, 32'h30);
      // beq not taken, operands differ by one
      r1 = rand_imm();
      prog_tab[5][0] = asm_i(OP_ADDI, 1, 0, r1);
      prog_tab[5][1] = asm_i(OP_ADDI, 2, 1, 16'h0001);
      prog_tab[5][2] = asm_i(OP_BEQ, 2, 1, 16'h0002);
      prog_tab[5][3] = asm_i(OP_ADDI, LED_REG, 0, 16'h0011);
      prog_tab[5][4] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0022);
      prog_tab[5][5] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0030);
      close_row(5, 6, 32'h11 + 32'h22 + 32'h30);
      // jump over one instruction
      prog_tab[6][0] = asm_i(OP_ADDI, LED_REG, 0, 16'h0005);
      prog_tab[6][1] = asm_j(3);
      prog_tab[6][2] = asm_i(OP_ADDI, LED_REG, 0, 16'h007f);
      prog_tab[6][3] = asm_i(OP_ADDI, LED_REG, LED_REG, 16'h0010);
      close_row(6, 4, 32'h5 + 32'h10);
      // random sum, round trip through memory, doubled
      r1 = rand_imm();
      r2 = rand_imm();
      r3 = rand_imm();
      prog_tab[7][0] = asm_i(OP_ADDI, LED_REG, 0, r1);
      prog_tab[7][1] = asm_i(OP_ADDI, LED_REG, LED_REG, r2);
      prog_tab[7][2] = asm_i(OP_ADDI, LED_REG, LED_REG, r3);
      prog_tab[7][3] = asm_i(OP_SW, LED_REG, 0, 16'h0000);
      prog_tab[7][4] = asm_i(OP_LW, 5, 0, 16'h0000);
      prog_tab[7][5] = asm_r(FN_ADD, LED_REG, 5, LED_REG);
      v = sext16(r1) + sext16(r2) + sext16(r3);
      close_row(7, 6, v + v);
   endtask

   task automatic reset_and_load(input int row);
      rst_n = 1'b0;
      for (int i = 0; i < ROM_WORDS; i++) begin
         rom[i] = (i < PROG_WORDS) ? prog_tab[row][i] : NOP_WORD;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      check_word("imem_addr_o", imem_addr, '0);
      check_led("led_o", led, 8'h00);
      rst_n = 1'b1;
   endtask

   task automatic run_row(input int row);
      word_t loop_addr;
      loop_addr = word_t'(end_idx[row] * 4);
      repeat (RUN_CYCLES) begin
         @(negedge clk);
         check_addr_bound(end_idx[row]);
      end
      check_led("led_o", led, exp_tab[row]);
      // settled pc toggles between the jump and the slot after it
      if (imem_addr != loop_addr && imem_addr != loop_addr + word_t'(4)) begin
         $display("row %0d never settled in its final jump loop", row);
         stop_on_error();
      end
   endtask

   initial begin
      rst_n     = 1'b0;
      imem_data = NOP_WORD;
      errors    = 0;
      lcg_state = 32'h0ed69d54;
      build_table();
      @(negedge clk);
      for (int r = 0; r < NUM_ROWS; r++) begin
         reset_and_load(r);
         run_row(r);
      end
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* mips_pipe.f */
design/mips_pkg.sv
design/pc_unit.sv
design/main_ctrl.sv
design/alu.sv
design/regfile.sv
design/hazard_unit.sv
design/data_ram.sv
design/mips_pipe_top.sv
bench/mips_pipe_asserts.sv
bench/mips_pipe_tb.sv

/* Makefile */
# Verilator build and run for the mips_pipe testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mips_pipe_tb
FILELIST  ?= mips_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
